/* hdl/dist_params.svh */
`ifndef DIST_PARAMS_SVH
`define DIST_PARAMS_SVH

//////////////////////////////
// distribution tree sizing
//////////////////////////////

// one operand word
`define DIST_DATA_WIDTH 32

// per switch command
// bit 1 high branch, bit 0 low branch
`define DIST_CMD_WIDTH 2

// leaf ports at the bottom of the tree
`define DIST_LEAVES 4

// saturating drop counter
`define DIST_DROP_WIDTH 16

`endif

/* hdl/dist_pkg.sv */
package dist_pkg;

	`include "dist_params.svh"

	//////////////////////////////
	// plain vector types
	//////////////////////////////

	// one data word
	typedef logic [`DIST_DATA_WIDTH-1:0] dist_data_t;

	// switch command
	// 00 none, 01 low, 10 high, 11 duplicate
	typedef logic [`DIST_CMD_WIDTH-1:0] dist_cmd_t;

	// destination mask, bit n selects leaf n
	typedef logic [`DIST_LEAVES-1:0] dist_mask_t;

	// dropped word count
	typedef logic [`DIST_DROP_WIDTH-1:0] dist_drop_t;

	//////////////////////////////
	// bundles
	//////////////////////////////

	// two output words of one switch
	typedef struct packed {
		dist_data_t high;
		dist_data_t low;
	} dist_pair_t;

	// all four leaf words, leaf 3 in the top bits
	typedef struct packed {
		dist_data_t leaf3;
		dist_data_t leaf2;
		dist_data_t leaf1;
		dist_data_t leaf0;
	} dist_leaf_bus_t;

	// root command plus the level 1 commands
	typedef struct packed {
		dist_cmd_t root;
		dist_cmd_t l1_high;
		dist_cmd_t l1_low;
	} dist_tree_cmd_t;

	// control fsm
	typedef enum logic {
		CFG_UNCONFIGURED = 1'b0,
		CFG_ROUTING      = 1'b1
	} dist_cfg_state_t;

endpackage

/* hdl/dist_switch_1x2.sv */
`timescale 1ns/1ns

module dist_switch_1x2
	import dist_pkg::*;
(
	input  logic       clk,
	input  logic       rst,

	// freeze level, low holds both branches
	input  logic       i_en,

	// incoming word
	input  logic       i_valid,
	input  dist_data_t i_data,

	// branch select, aligned with i_data
	input  dist_cmd_t  i_cmd,

	// [1] high branch, [0] low branch
	output logic [1:0] o_valid,
	output dist_pair_t o_data
);

	//////////////////////////////
	// branch select
	//////////////////////////////

	// values loaded on the next enabled edge
	logic [1:0] valid_next;
	dist_pair_t data_next;

	always_comb
	begin
		// default is nothing routed
		valid_next = 2'b00;
		data_next  = '0;
		if (i_valid)
		begin
			case (i_cmd)
				2'b01:
				begin
					// low branch only
					valid_next     = 2'b01;
					data_next.low  = i_data;
				end
				2'b10:
				begin
					// high branch only
					valid_next     = 2'b10;
					data_next.high = i_data;
				end
				2'b11:
				begin
					// duplicate onto both
					valid_next     = 2'b11;
					data_next.high = i_data;
					data_next.low  = i_data;
				end
				default:
				begin
					// none, word goes nowhere
					valid_next = 2'b00;
					data_next  = '0;
				end
			endcase
		end
	end

	//////////////////////////////
	// output registers
	//////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			o_valid <= 2'b00;
			o_data  <= '0;
		end
		else if (i_en)
		begin
			o_valid <= valid_next;
			o_data  <= data_next;
		end
		// disabled edge keeps both branches as they are
	end

	//////////////////////////////
	// checks
	//////////////////////////////

	// a frozen edge never raises a branch valid
	assert property (@(posedge clk) disable iff (rst)
		!i_en |=> ((o_valid & ~$past(o_valid)) == 2'b00))
	else
		$error("dist_switch_1x2 valid rose across a disabled edge");

endmodule

/* hdl/dist_ctrl.sv */
`timescale 1ns/1ns

module dist_ctrl
	import dist_pkg::*;
(
	input  logic           clk,
	input  logic           rst,

	// freeze level
	input  logic           i_en,

	// mask load strobe
	input  logic           i_cfg_valid,
	input  dist_mask_t     i_cfg_mask,

	// word strobe from the source port
	input  logic           i_valid,

	// qualified valid into the root switch
	output logic           o_root_valid,

	// root command now, level 1 commands one stage later
	output dist_tree_cmd_t o_cmd,

	output dist_drop_t     o_drop_count
);

	//////////////////////////////
	// configuration fsm
	//////////////////////////////

	dist_cfg_state_t cfg_state;
	dist_cfg_state_t cfg_state_next;

	// destination mask in use for new words
	dist_mask_t cfg_mask;

	// strobe only counts on an enabled edge
	logic cfg_load;

	assign cfg_load = i_en & i_cfg_valid;

	always_comb
	begin
		cfg_state_next = cfg_state;
		case (cfg_state)
			CFG_UNCONFIGURED:
			begin
				// first mask arms the tree
				if (cfg_load)
					cfg_state_next = CFG_ROUTING;
			end
			CFG_ROUTING:
			begin
				// stays here until reset
				cfg_state_next = CFG_ROUTING;
			end
			default:
			begin
				cfg_state_next = CFG_UNCONFIGURED;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			cfg_state <= CFG_UNCONFIGURED;
			cfg_mask  <= '0;
		end
		else
		begin
			cfg_state <= cfg_state_next;
			// every strobe reloads the mask
			if (cfg_load)
				cfg_mask <= i_cfg_mask;
		end
	end

	//////////////////////////////
	// mask decode
	//////////////////////////////

	// word can be routed somewhere
	logic route_ok;

	// root command for the word at the root this cycle
	dist_cmd_t root_cmd;

	// level 1 commands for the word at the root this cycle
	dist_cmd_t l1_high_cmd;
	dist_cmd_t l1_low_cmd;

	assign route_ok = (cfg_state == CFG_ROUTING) && (cfg_mask != '0);

	// root high branch feeds leaves 3:2, low branch feeds 1:0
	assign root_cmd     = {|cfg_mask[3:2], |cfg_mask[1:0]};
	assign o_root_valid = i_valid & route_ok;

	// leaf switch commands are the mask halves
	assign l1_high_cmd = cfg_mask[3:2];
	assign l1_low_cmd  = cfg_mask[1:0];

	//////////////////////////////
	// level 1 command stage
	//////////////////////////////

	// commands for the word now at level 1
	dist_cmd_t l1_high_q;
	dist_cmd_t l1_low_q;

	// follows the word from root to level 1
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			l1_high_q <= '0;
			l1_low_q  <= '0;
		end
		else if (i_en)
		begin
			l1_high_q <= l1_high_cmd;
			l1_low_q  <= l1_low_cmd;
		end
	end

	assign o_cmd = {root_cmd, l1_high_q, l1_low_q};

	//////////////////////////////
	// drop counter
	//////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
			o_drop_count <= '0;
		else if (i_en && i_valid && !route_ok)
		begin
			// saturate at all ones
			if (o_drop_count != '1)
				o_drop_count <= o_drop_count + dist_drop_t'(1);
		end
	end

	// qualified word always has a branch to go to
	assert property (@(posedge clk) disable iff (rst)
		o_root_valid |-> (o_cmd.root != 2'b00))
	else
		$error("dist_ctrl root valid with empty root command");

	// count only moves up between resets
	assert property (@(posedge clk) disable iff (rst)
		1'b1 |=> (o_drop_count >= $past(o_drop_count)))
	else
		$error("dist_ctrl drop count went down");

endmodule

/* hdl/dist_net_top.sv */
`timescale 1ns/1ns

module dist_net_top
	import dist_pkg::*;
(
	input  logic           clk,
	input  logic           rst,

	// freeze level for the whole tree
	input  logic           i_en,

	// destination mask load
	input  logic           i_cfg_valid,
	input  dist_mask_t     i_cfg_mask,

	// source port
	input  logic           i_valid,
	input  dist_data_t     i_data,

	// leaf ports, bit n is leaf n
	output dist_mask_t     o_leaf_valid,
	output dist_leaf_bus_t o_leaf_data,

	output dist_drop_t     o_drop_count
);

	//////////////////////////////
	// control
	//////////////////////////////

	logic           root_valid;
	dist_tree_cmd_t tree_cmd;

	dist_ctrl i_dist_ctrl (
		.clk          (clk),
		.rst          (rst),
		.i_en         (i_en),
		.i_cfg_valid  (i_cfg_valid),
		.i_cfg_mask   (i_cfg_mask),
		.i_valid      (i_valid),
		.o_root_valid (root_valid),
		.o_cmd        (tree_cmd),
		.o_drop_count (o_drop_count)
	);

	//////////////////////////////
	// level 0, root switch
	//////////////////////////////

	// [1] toward leaves 3:2, [0] toward leaves 1:0
	logic [1:0] root_out_valid;
	dist_pair_t root_out_data;

	dist_switch_1x2 i_root (
		.clk     (clk),
		.rst     (rst),
		.i_en    (i_en),
		.i_valid (root_valid),
		.i_data  (i_data),
		.i_cmd   (tree_cmd.root),
		.o_valid (root_out_valid),
		.o_data  (root_out_data)
	);

	//////////////////////////////
	// level 1, leaf switches
	//////////////////////////////

	// high switch drives leaves 3 and 2
	dist_switch_1x2 i_leaf_high (
		.clk     (clk),
		.rst     (rst),
		.i_en    (i_en),
		.i_valid (root_out_valid[1]),
		.i_data  (root_out_data.high),
		.i_cmd   (tree_cmd.l1_high),
		.o_valid (o_leaf_valid[3:2]),
		.o_data  ({o_leaf_data.leaf3, o_leaf_data.leaf2})
	);

	// low switch drives leaves 1 and 0
	dist_switch_1x2 i_leaf_low (
		.clk     (clk),
		.rst     (rst),
		.i_en    (i_en),
		.i_valid (root_out_valid[0]),
		.i_data  (root_out_data.low),
		.i_cmd   (tree_cmd.l1_low),
		.o_valid (o_leaf_valid[1:0]),
		.o_data  ({o_leaf_data.leaf1, o_leaf_data.leaf0})
	);

endmodule

/* test/dist_net_checks.svh */
`ifndef DIST_NET_CHECKS_SVH
`define DIST_NET_CHECKS_SVH

	//////////////////////////////
	// reset state
	//////////////////////////////

	// first cycle out of reset, nothing on the leaves
	assert property (@(posedge clk) $fell(rst) |-> (o_leaf_valid == '0))
	else
		abort_run($sformatf("CHECK FAILED o_leaf_valid expected %h actual %h",
			dist_mask_t'(0), $sampled(o_leaf_valid)));

	// leaf data cleared too
	assert property (@(posedge clk) $fell(rst) |-> (o_leaf_data == '0))
	else
		abort_run($sformatf("CHECK FAILED o_leaf_data expected %h actual %h",
			dist_leaf_bus_t'(0), $sampled(o_leaf_data)));

	// no drops counted yet
	assert property (@(posedge clk) $fell(rst) |-> (o_drop_count == '0))
	else
		abort_run($sformatf("CHECK FAILED o_drop_count expected %h actual %h",
			dist_drop_t'(0), $sampled(o_drop_count)));

	//////////////////////////////
	// leaf ports against the model
	//////////////////////////////

	// which leaves carry a word
	assert property (@(posedge clk) disable iff (rst) o_leaf_valid == exp_leaf_valid)
	else
		abort_run($sformatf("CHECK FAILED o_leaf_valid expected %h actual %h",
			$sampled(exp_leaf_valid), $sampled(o_leaf_valid)));

	// the word itself, zero on unselected lanes
	assert property (@(posedge clk) disable iff (rst) o_leaf_data == exp_leaf_data)
	else
		abort_run($sformatf("CHECK FAILED o_leaf_data expected %h actual %h",
			$sampled(exp_leaf_data), $sampled(o_leaf_data)));

	// dropped words, unconfigured or zero mask
	assert property (@(posedge clk) disable iff (rst) o_drop_count == exp_drop_count)
	else
		abort_run($sformatf("CHECK FAILED o_drop_count expected %h actual %h",
			$sampled(exp_drop_count), $sampled(o_drop_count)));

	//////////////////////////////
	// structural rules
	//////////////////////////////

	// a frozen edge leaves every leaf port untouched
	assert property (@(posedge clk) disable iff (rst)
		!i_en |=> ($stable(o_leaf_valid) && $stable(o_leaf_data)))
	else
		abort_run("leaf outputs changed across a frozen clock edge");

	// lanes without a valid never show data
	assert property (@(posedge clk) disable iff (rst)
		idle_leaves_zero(o_leaf_valid, o_leaf_data))
	else
		abort_run("a leaf without valid carried nonzero data");

`endif

/* test/dist_net_tb.sv */
`timescale 1ns/1ns

module dist_net_tb
	import dist_pkg::*;
();

	//////////////////////////////
	// run length
	//////////////////////////////

	localparam int RESET_CYCLES  = 16;
	// worst drain tail with i_en high
	localparam int DRAIN_MAX     = 4;
	localparam int UNCFG_WORDS   = 6;
	localparam int RANDOM_MASKS  = 24;
	localparam int ZERO_WORDS    = 5;
	localparam int STREAM_WORDS  = 40;
	localparam int FREEZE_CYCLES = 200;

	// every phase plus its drain
	localparam int STIM_CYCLES = RESET_CYCLES + 2
		+ 1 + UNCFG_WORDS + DRAIN_MAX
		+ 4 * (2 + DRAIN_MAX)
		+ (RANDOM_MASKS + 2) * (2 + DRAIN_MAX)
		+ 1 + ZERO_WORDS + DRAIN_MAX
		+ STREAM_WORDS + DRAIN_MAX
		+ FREEZE_CYCLES + DRAIN_MAX;
	localparam int TIMEOUT_CYCLES = 3 * STIM_CYCLES;

	//////////////////////////////
	// DUT
	//////////////////////////////

	logic           clk = 1'b0;
	logic           rst;
	logic           i_en;
	logic           i_cfg_valid;
	dist_mask_t     i_cfg_mask;
	logic           i_valid;
	dist_data_t     i_data;
	dist_mask_t     o_leaf_valid;
	dist_leaf_bus_t o_leaf_data;
	dist_drop_t     o_drop_count;

	// 10 ns period
	always #5 clk = ~clk;

	dist_net_top i_dist_net_top (
		.clk          (clk),
		.rst          (rst),
		.i_en         (i_en),
		.i_cfg_valid  (i_cfg_valid),
		.i_cfg_mask   (i_cfg_mask),
		.i_valid      (i_valid),
		.i_data       (i_data),
		.o_leaf_valid (o_leaf_valid),
		.o_leaf_data  (o_leaf_data),
		.o_drop_count (o_drop_count)
	);

	//////////////////////////////
	// helpers
	//////////////////////////////

	// end the run on the first problem
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Test failures found");
		$fatal(1, "simulation stopped");
	endtask

	// copy a word onto every leaf named in the mask
	function automatic dist_leaf_bus_t spread_word(dist_mask_t mask, dist_data_t data);
		dist_leaf_bus_t bus;
		bus.leaf0 = mask[0] ? data : '0;
		bus.leaf1 = mask[1] ? data : '0;
		bus.leaf2 = mask[2] ? data : '0;
		bus.leaf3 = mask[3] ? data : '0;
		return bus;
	endfunction

	// true when every lane without valid is zero
	function automatic logic idle_leaves_zero(dist_mask_t valid, dist_leaf_bus_t bus);
		return (valid[0] || bus.leaf0 == '0) && (valid[1] || bus.leaf1 == '0)
			&& (valid[2] || bus.leaf2 == '0) && (valid[3] || bus.leaf3 == '0);
	endfunction

	//////////////////////////////
	// reference model
	//////////////////////////////

	// one word in flight, with the mask it was accepted under
	typedef struct packed {
		logic       valid;
		dist_mask_t mask;
		dist_data_t data;
	} flight_t;

	flight_t        flight_q[$];
	logic           model_routing;
	dist_mask_t     model_mask;
	dist_mask_t     exp_leaf_valid;
	dist_leaf_bus_t exp_leaf_data;
	dist_drop_t     exp_drop_count;
	int             cycle_count = 0;

	always @(posedge clk)
	begin
		flight_t entry;
		flight_t done;
		if (rst)
		begin
			flight_q.delete();
			model_routing  <= 1'b0;
			model_mask     <= '0;
			exp_leaf_valid <= '0;
			exp_leaf_data  <= '0;
			exp_drop_count <= '0;
		end
		else if (i_en)
		begin
			// accepted only once configured and with some leaf selected
			entry.valid = i_valid && model_routing && (model_mask != '0);
			entry.mask  = model_mask;
			entry.data  = i_data;
			// word taken one enabled edge ago lands on the leaves now
			if (flight_q.size() > 0)
			begin
				done = flight_q.pop_front();
				exp_leaf_valid <= done.valid ? done.mask : '0;
				exp_leaf_data  <= spread_word(done.valid ? done.mask : '0, done.data);
			end
			flight_q.push_back(entry);
			// rejected words count, saturating
			if (i_valid && !entry.valid && exp_drop_count != '1)
				exp_drop_count <= exp_drop_count + 1'b1;
			// new mask applies from the next word on
			if (i_cfg_valid)
			begin
				model_routing <= 1'b1;
				model_mask    <= i_cfg_mask;
			end
		end
	end

	`include "dist_net_checks.svh"

	// hang guard
	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
			abort_run($sformatf("timeout, the run did not finish within %0d cycles",
				TIMEOUT_CYCLES));
	end

	//////////////////////////////
	// stimulus
	//////////////////////////////

	// inputs change 1 ns after the edge
	task automatic step();
		@(posedge clk);
		#1;
	endtask

	// one source cycle, held until the next edge samples it
	task automatic drive(input logic en, input logic cfg, input dist_mask_t mask,
		input logic valid, input dist_data_t data);
		i_en        = en;
		i_cfg_valid = cfg;
		i_cfg_mask  = mask;
		i_valid     = valid;
		i_data      = data;
		step();
	endtask

	// idle with i_en high until no word is left in the tree
	task automatic drain();
		while (flight_q.size() > 0 && flight_q[0].valid)
			drive(1'b1, 1'b0, '0, 1'b0, '0);
		// one more edge so the last leaf pattern gets checked
		drive(1'b1, 1'b0, '0, 1'b0, '0);
	endtask

	// load a mask, then one word under it
	task automatic route_one(input dist_mask_t mask);
		drive(1'b1, 1'b1, mask, 1'b0, '0);
		drive(1'b1, 1'b0, '0, 1'b1, dist_data_t'($urandom()));
		drain();
	endtask

	initial
	begin
		logic en;
		void'($urandom(13));
		rst         = 1'b1;
		i_en        = 1'b0;
		i_cfg_valid = 1'b0;
		i_cfg_mask  = '0;
		i_valid     = 1'b0;
		i_data      = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst = 1'b0;

		// frozen strobe is ignored, so these all drop
		drive(1'b0, 1'b1, 4'hf, 1'b1, dist_data_t'($urandom()));
		for (int i = 0; i < UNCFG_WORDS; i++)
			drive(1'b1, 1'b0, '0, 1'b1, dist_data_t'($urandom()));
		drain();

		// one-hot masks
		for (int n = 0; n < 4; n++)
			route_one(dist_mask_t'(1 << n));

		// broadcast, cross-half, then random multicast
		route_one(4'hf);
		route_one(4'h9);
		for (int i = 0; i < RANDOM_MASKS; i++)
			route_one(dist_mask_t'($urandom_range(15, 1)));

		// configured but empty mask
		drive(1'b1, 1'b1, '0, 1'b0, '0);
		for (int i = 0; i < ZERO_WORDS; i++)
			drive(1'b1, 1'b0, '0, 1'b1, dist_data_t'($urandom()));
		drain();

		// a word every cycle, mask reloaded alongside each
		for (int i = 0; i < STREAM_WORDS; i++)
			drive(1'b1, 1'b1, dist_mask_t'($urandom_range(15, 0)), 1'b1,
				dist_data_t'($urandom()));
		drain();

		// random freezes with both strobes toggling underneath
		for (int i = 0; i < FREEZE_CYCLES; i++)
		begin
			en = ($urandom_range(3, 0) != 0);
			drive(en, ($urandom_range(7, 0) == 0), dist_mask_t'($urandom_range(15, 0)),
				1'($urandom_range(1, 0)), dist_data_t'($urandom()));
		end
		drain();

		$display("All tests passed!");
		$finish;
	end

endmodule

/* vlog.f */
+incdir+hdl
+incdir+test
hdl/dist_pkg.sv
hdl/dist_switch_1x2.sv
hdl/dist_ctrl.sv
hdl/dist_net_top.sv
test/dist_net_tb.sv
